// File: hw/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Core word width
`define RV_XLEN 32

// Data memory depth in words
`define RV_DMEM_WORDS 256

// First fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

// File: hw/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

typedef logic [`RV_XLEN-1:0] instr_val;
typedef logic [`RV_XLEN-1:0] data_val;

typedef enum logic [6:0] {
    OPC_L     = 7'b0000011,
    OPC_I     = 7'b0010011,
    OPC_S     = 7'b0100011,
    OPC_R     = 7'b0110011,
    OPC_B     = 7'b1100011,
    OPC_AUIPC = 7'b0010111,
    OPC_LUI   = 7'b0110111,
    OPC_JAL   = 7'b1101111,
    OPC_JALR  = 7'b1100111
} opcode_e;

typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
} instr_r_t;

typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
} instr_i_t;

typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
} instr_s_t;

typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
} instr_b_t;

typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
} instr_u_t;

typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
} instr_jal_t;

typedef union packed {
    instr_r_t   R;
    instr_i_t   I;
    instr_s_t   S;
    instr_b_t   B;
    instr_u_t   U;
    instr_jal_t JAL;
} instr_body;

typedef struct packed {
    instr_body body;
    opcode_e   opc;
} instr;

// Top bit is funct7[5]; 10xx codes are branch compares on funct3[2:1]
typedef enum logic [3:0] {
    ALU_ADD     = 4'b0000,
    ALU_SLL     = 4'b0001,
    ALU_SLT     = 4'b0010,
    ALU_SLTU    = 4'b0011,
    ALU_XOR     = 4'b0100,
    ALU_SRL     = 4'b0101,
    ALU_OR      = 4'b0110,
    ALU_AND     = 4'b0111,
    ALU_SUB     = 4'b1000,  // Also EQ and NE compare
    ALU_CMP_LT  = 4'b1010,  // LT and GE
    ALU_CMP_LTU = 4'b1011,  // LTU and GEU
    ALU_SRA     = 4'b1101
} alu_optr;

typedef enum logic {
    ALU_OPND_1_REG,
    ALU_OPND_1_PC
} alu_opnd_1_sel;

typedef enum logic {
    ALU_OPND_2_REG,
    ALU_OPND_2_IMM
} alu_opnd_2_sel;

typedef enum logic [1:0] {
    PL0_STALL_NONE,
    PL0_STALL_1_BRANCH,
    PL0_STALL_1_ALU,
    PL0_STALL_IMM
} pl0_stall_state;

typedef struct packed {
    logic           valid;
    instr_val       pc;
    data_val        rs1_val;
    data_val        rs2_val;
    logic [4:0]     rd;
    data_val        imm;
    alu_opnd_1_sel  opnd_1_sel;
    alu_opnd_2_sel  opnd_2_sel;
    alu_optr        optr;
    logic           use_optr;
    data_val        alt_out;
    logic           reg_wr_en;
    logic           mem_rd_en;
    logic           mem_wr_en;
    logic           br_inv;     // funct3[0], flips the compare
    pl0_stall_state stall_state;
} de_bundle_t;

typedef struct packed {
    logic       valid;
    instr_val   pc;
    logic [4:0] rd;
    logic       wr_en;
    data_val    data;
} retire_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_optr i_optr,
    input  rv_pkg::data_val i_opnd_1,
    input  rv_pkg::data_val i_opnd_2,
    output rv_pkg::data_val o_result,
    output logic            o_cmp
);

import rv_pkg::*;

logic       lt_s;
logic       lt_u;
logic [4:0] shamt;

assign lt_s  = $signed(i_opnd_1) < $signed(i_opnd_2);
assign lt_u  = i_opnd_1 < i_opnd_2;
assign shamt = i_opnd_2[4:0];

always_comb
begin
    case (i_optr)
        ALU_ADD:  o_result = i_opnd_1 + i_opnd_2;
        ALU_SUB:  o_result = i_opnd_1 - i_opnd_2;
        ALU_SLL:  o_result = i_opnd_1 << shamt;
        ALU_SLT:  o_result = data_val'(lt_s);
        ALU_SLTU: o_result = data_val'(lt_u);
        ALU_XOR:  o_result = i_opnd_1 ^ i_opnd_2;
        ALU_SRL:  o_result = i_opnd_1 >> shamt;
        ALU_SRA:  o_result = data_val'($signed(i_opnd_1) >>> shamt);
        ALU_OR:   o_result = i_opnd_1 | i_opnd_2;
        ALU_AND:  o_result = i_opnd_1 & i_opnd_2;
        default:  o_result = '0;
    endcase
end

// Inverted forms (NE, GE, GEU) are applied by execute
always_comb
begin
    case (i_optr)
        ALU_SUB:     o_cmp = (i_opnd_1 == i_opnd_2);
        ALU_CMP_LT:  o_cmp = lt_s;
        ALU_CMP_LTU: o_cmp = lt_u;
        default:     o_cmp = 1'b0;
    endcase
end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_unit (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  rv_pkg::instr           i_instr,
    input  rv_pkg::data_val        i_imm,
    input  logic                   i_stall,
    input  rv_pkg::pl0_stall_state i_stall_state,
    input  logic                   i_redirect,
    input  rv_pkg::instr_val       i_redirect_pc,
    output rv_pkg::instr_val       o_pc,
    output logic                   o_valid
);

import rv_pkg::*;

instr_val pc_q;
instr_val pc_next;
logic     wait_q;   // Branch or JALR resolving in execute

assign o_pc    = pc_q;
assign o_valid = !wait_q;

always_comb
begin
    pc_next = pc_q;
    if (o_valid)
    begin
        case (i_stall_state)
            PL0_STALL_NONE:
                pc_next = pc_q + 4;
            PL0_STALL_IMM:  // JAL target taken here
                pc_next = (i_instr.opc == OPC_JAL) ? pc_q + i_imm : pc_q + 4;
            default:
                pc_next = pc_q;  // Hold for redirect
        endcase
    end
end

always_ff @(posedge i_clk)
begin
    if (!i_rst_n)
    begin
        pc_q   <= `RV_RESET_PC;
        wait_q <= 1'b0;
    end
    else if (i_redirect)
    begin
        pc_q   <= i_redirect_pc;
        wait_q <= 1'b0;
    end
    else
    begin
        pc_q   <= pc_next;
        wait_q <= o_valid && i_stall;
    end
end

a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n) pc_q[1:0] == 2'b00)
    else $error("fetch_unit: PC %h not word aligned", pc_q);

endmodule

// File: hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  rv_pkg::instr           i_cur_instr_val,
    input  rv_pkg::instr_val       i_pc_val,
    output rv_pkg::pl0_stall_state o_pl0_stall_state_val,
    output logic                   o_reg_wr_en,
    output rv_pkg::alu_opnd_1_sel  o_alu_opnd_1_sel_val,
    output rv_pkg::alu_opnd_2_sel  o_alu_opnd_2_sel_val,
    output rv_pkg::alu_optr        o_alu_optr_val,
    output logic                   o_alu_use_optr,
    output rv_pkg::data_val        o_alu_alt_out_val,
    output logic                   o_mem_wr_en,
    output logic                   o_mem_rd_en,
    output rv_pkg::data_val        o_imm_val,
    output logic                   o_stall
);

import rv_pkg::*;

typedef enum logic [2:0] {
    IMM_FMT_I,
    IMM_FMT_I_SHIFT,
    IMM_FMT_S,
    IMM_FMT_B,
    IMM_FMT_U,
    IMM_FMT_JAL
} imm_fmt_e;

imm_fmt_e   imm_fmt;
logic [2:0] funct3;
logic       funct7_5;
logic       is_shift;
logic       opc_known;
data_val    u_imm;

assign funct3      = i_cur_instr_val.body.R.funct3;
assign funct7_5    = i_cur_instr_val.body.R.funct7[5];
assign is_shift    = (funct3 == 3'b001) || (funct3 == 3'b101);  // SLLI, SRLI, SRAI
assign u_imm       = {i_cur_instr_val.body.U.imm_31_12, 12'h000};
assign o_mem_wr_en = (i_cur_instr_val.opc == OPC_S);
assign o_mem_rd_en = (i_cur_instr_val.opc == OPC_L);

always_comb
begin
    // Most formats add a register and an immediate
    imm_fmt               = IMM_FMT_I;
    o_pl0_stall_state_val = PL0_STALL_NONE;
    o_alu_opnd_1_sel_val  = ALU_OPND_1_REG;
    o_alu_opnd_2_sel_val  = ALU_OPND_2_IMM;
    o_alu_optr_val        = ALU_ADD;
    o_alu_use_optr        = 1'b1;
    o_alu_alt_out_val     = '0;
    o_reg_wr_en           = 1'b0;
    o_stall               = 1'b0;
    opc_known             = 1'b1;
    case (i_cur_instr_val.opc)
        OPC_L:
            o_reg_wr_en = 1'b1;
        OPC_I:
        begin
            imm_fmt        = is_shift ? IMM_FMT_I_SHIFT : IMM_FMT_I;
            o_alu_optr_val = alu_optr'({funct3 == 3'b101 ? funct7_5 : 1'b0, funct3});
            o_reg_wr_en    = 1'b1;
        end
        OPC_S:
            imm_fmt = IMM_FMT_S;
        OPC_R:
        begin
            o_alu_opnd_2_sel_val = ALU_OPND_2_REG;
            o_alu_optr_val       = alu_optr'({funct7_5, funct3});
            o_reg_wr_en          = 1'b1;
        end
        OPC_B:
        begin
            imm_fmt               = IMM_FMT_B;
            o_pl0_stall_state_val = PL0_STALL_1_BRANCH;
            o_alu_opnd_2_sel_val  = ALU_OPND_2_REG;
            o_alu_optr_val        = alu_optr'({2'b10, funct3[2:1]});
            o_alu_use_optr        = 1'b0;
            o_stall               = 1'b1;
        end
        OPC_AUIPC:
        begin
            imm_fmt              = IMM_FMT_U;
            o_alu_opnd_1_sel_val = ALU_OPND_1_PC;
            o_reg_wr_en          = 1'b1;
        end
        OPC_LUI:
        begin
            imm_fmt           = IMM_FMT_U;
            o_alu_use_optr    = 1'b0;
            o_alu_alt_out_val = u_imm;  // Bypasses the ALU
            o_reg_wr_en       = 1'b1;
        end
        OPC_JAL:
        begin
            imm_fmt               = IMM_FMT_JAL;
            o_pl0_stall_state_val = PL0_STALL_IMM;
            o_alu_use_optr        = 1'b0;
            o_alu_alt_out_val     = i_pc_val + 4;  // Link value
            o_reg_wr_en           = 1'b1;
        end
        OPC_JALR:
        begin
            o_pl0_stall_state_val = PL0_STALL_1_ALU;
            o_alu_use_optr        = 1'b0;
            o_alu_alt_out_val     = i_pc_val + 4;
            o_reg_wr_en           = 1'b1;
            o_stall               = 1'b1;
        end
        default:
        begin
            o_alu_use_optr = 1'b0;  // No writes, no stall
            opc_known      = 1'b0;
        end
    endcase
end

always_comb
begin
    case (imm_fmt)
        IMM_FMT_I:
            o_imm_val = {{20{i_cur_instr_val.body.I.imm_11_0[11]}},
                         i_cur_instr_val.body.I.imm_11_0};
        IMM_FMT_I_SHIFT:
            o_imm_val = {27'd0, i_cur_instr_val.body.I.imm_11_0[4:0]};  // shamt only
        IMM_FMT_S:
            o_imm_val = {{20{i_cur_instr_val.body.S.imm_11_5[6]}},
                         i_cur_instr_val.body.S.imm_11_5,
                         i_cur_instr_val.body.S.imm_4_0};
        IMM_FMT_B:
            o_imm_val = {{19{i_cur_instr_val.body.B.imm_12}},
                         i_cur_instr_val.body.B.imm_12,
                         i_cur_instr_val.body.B.imm_11,
                         i_cur_instr_val.body.B.imm_10_5,
                         i_cur_instr_val.body.B.imm_4_1,
                         1'b0};
        IMM_FMT_U:
            o_imm_val = u_imm;
        IMM_FMT_JAL:
            o_imm_val = {{11{i_cur_instr_val.body.JAL.imm_20}},
                         i_cur_instr_val.body.JAL.imm_20,
                         i_cur_instr_val.body.JAL.imm_19_12,
                         i_cur_instr_val.body.JAL.imm_11,
                         i_cur_instr_val.body.JAL.imm_10_1,
                         1'b0};
        default:
            o_imm_val = '0;
    endcase
end

// Combinational block, so the check is deferred to the end of the time step
always_comb
begin
    if (opc_known)
    begin
        a_no_x: assert final (!$isunknown({o_pl0_stall_state_val, o_reg_wr_en,
                                           o_alu_optr_val, o_alu_alt_out_val,
                                           o_imm_val, o_stall}))
            else $error("decoder: X on outputs for opcode %b", i_cur_instr_val.opc);
    end
end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic [4:0]      i_rs1,
    input  logic [4:0]      i_rs2,
    input  logic            i_wr_en,
    input  logic [4:0]      i_rd,
    input  rv_pkg::data_val i_wr_data,
    output rv_pkg::data_val o_rs1_val,
    output rv_pkg::data_val o_rs2_val
);

import rv_pkg::*;

data_val regs [32];
logic    wr_live;

assign wr_live = i_wr_en && (i_rd != 5'd0);  // x0 never written

// Same-cycle write is forwarded to the reads
assign o_rs1_val = (i_rs1 == 5'd0) ? '0 : (wr_live && i_rd == i_rs1) ? i_wr_data : regs[i_rs1];
assign o_rs2_val = (i_rs2 == 5'd0) ? '0 : (wr_live && i_rd == i_rs2) ? i_wr_data : regs[i_rs2];

always_ff @(posedge i_clk)
begin
    if (!i_rst_n)
    begin
        for (int i = 0; i < 32; i++)
            regs[i] <= '0;
    end
    else if (wr_live)
        regs[i_rd] <= i_wr_data;
end

endmodule

// File: hw/de_pipe_reg.sv
`timescale 1ns/1ps

module de_pipe_reg (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  rv_pkg::de_bundle_t i_bundle,
    output rv_pkg::de_bundle_t o_bundle
);

import rv_pkg::*;

always_ff @(posedge i_clk)
begin
    o_bundle <= i_bundle;
    if (!i_rst_n || !i_bundle.valid)
    begin
        // Bubble carries no side effects
        o_bundle.valid     <= 1'b0;
        o_bundle.reg_wr_en <= 1'b0;
        o_bundle.mem_rd_en <= 1'b0;
        o_bundle.mem_wr_en <= 1'b0;
    end
end

// Fetch holds the PC one cycle behind every branch
a_branch_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_bundle.valid && o_bundle.stall_state == PL0_STALL_1_BRANCH |=> !o_bundle.valid)
    else $error("de_pipe_reg: branch at %h not followed by a bubble", $past(o_bundle.pc));

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_unit (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  rv_pkg::de_bundle_t i_bundle,
    output logic               o_wr_en,
    output logic [4:0]         o_rd,
    output rv_pkg::data_val    o_wr_data,
    output logic               o_redirect,
    output rv_pkg::instr_val   o_redirect_pc,
    output rv_pkg::retire_t    o_retire
);

import rv_pkg::*;

localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

data_val             dmem [`RV_DMEM_WORDS];
data_val             opnd_1;
data_val             opnd_2;
data_val             alu_result;
data_val             load_data;
logic                cmp;
logic                taken;
logic [DMEM_AW-1:0]  dmem_idx;

assign opnd_1 = (i_bundle.opnd_1_sel == ALU_OPND_1_PC) ? i_bundle.pc : i_bundle.rs1_val;
assign opnd_2 = (i_bundle.opnd_2_sel == ALU_OPND_2_IMM) ? i_bundle.imm : i_bundle.rs2_val;

alu alu_inst (
    .i_optr   (i_bundle.optr),
    .i_opnd_1 (opnd_1),
    .i_opnd_2 (opnd_2),
    .o_result (alu_result),
    .o_cmp    (cmp)
);

assign dmem_idx  = alu_result[DMEM_AW+1:2];  // Word index
assign load_data = dmem[dmem_idx];

always_ff @(posedge i_clk)
begin
    if (i_rst_n && i_bundle.valid && i_bundle.mem_wr_en)
        dmem[dmem_idx] <= i_bundle.rs2_val;
end

assign o_wr_en   = i_bundle.valid && i_bundle.reg_wr_en;
assign o_rd      = i_bundle.rd;
assign o_wr_data = i_bundle.mem_rd_en ? load_data
                 : i_bundle.use_optr  ? alu_result
                 : i_bundle.alt_out;

assign taken      = cmp ^ i_bundle.br_inv;
assign o_redirect = i_bundle.valid && (i_bundle.stall_state == PL0_STALL_1_BRANCH
                                       || i_bundle.stall_state == PL0_STALL_1_ALU);
assign o_redirect_pc = (i_bundle.stall_state == PL0_STALL_1_ALU) ? {alu_result[31:1], 1'b0}
                     : taken ? i_bundle.pc + i_bundle.imm
                     : i_bundle.pc + 4;

assign o_retire = '{valid: i_bundle.valid, pc: i_bundle.pc, rd: i_bundle.rd,
                    wr_en: o_wr_en, data: o_wr_data};

// Bubbles arrive with both memory enables cleared
a_mem_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_bundle.mem_rd_en && i_bundle.mem_wr_en)
        && (i_bundle.valid || !(i_bundle.mem_rd_en || i_bundle.mem_wr_en)))
    else $error("execute_unit: bad memory enables at %h", i_bundle.pc);

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    output rv_pkg::instr_val o_imem_addr,
    input  rv_pkg::instr_val i_imem_data,
    output rv_pkg::retire_t  o_retire
);

import rv_pkg::*;

instr           cur_instr;
logic           fetch_valid;
pl0_stall_state stall_state;
logic           stall;
logic           reg_wr_en;
alu_opnd_1_sel  opnd_1_sel;
alu_opnd_2_sel  opnd_2_sel;
alu_optr        optr;
logic           use_optr;
data_val        alt_out;
logic           mem_wr_en;
logic           mem_rd_en;
data_val        imm;
data_val        rs1_val;
data_val        rs2_val;
de_bundle_t     bundle_d;
de_bundle_t     bundle_q;
logic           wb_en;
logic [4:0]     wb_rd;
data_val        wb_data;
logic           redirect;
instr_val       redirect_pc;

assign cur_instr = i_imem_data;

fetch_unit fetch_unit_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_instr       (cur_instr),
    .i_imm         (imm),
    .i_stall       (stall),
    .i_stall_state (stall_state),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_pc          (o_imem_addr),
    .o_valid       (fetch_valid)
);

decoder decoder_inst (
    .i_cur_instr_val       (cur_instr),
    .i_pc_val              (o_imem_addr),
    .o_pl0_stall_state_val (stall_state),
    .o_reg_wr_en           (reg_wr_en),
    .o_alu_opnd_1_sel_val  (opnd_1_sel),
    .o_alu_opnd_2_sel_val  (opnd_2_sel),
    .o_alu_optr_val        (optr),
    .o_alu_use_optr        (use_optr),
    .o_alu_alt_out_val     (alt_out),
    .o_mem_wr_en           (mem_wr_en),
    .o_mem_rd_en           (mem_rd_en),
    .o_imm_val             (imm),
    .o_stall               (stall)
);

reg_file reg_file_inst (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_rs1     (cur_instr.body.R.rs1),
    .i_rs2     (cur_instr.body.R.rs2),
    .i_wr_en   (wb_en),
    .i_rd      (wb_rd),
    .i_wr_data (wb_data),
    .o_rs1_val (rs1_val),
    .o_rs2_val (rs2_val)
);

assign bundle_d = '{valid: fetch_valid, pc: o_imem_addr, rs1_val: rs1_val,
                    rs2_val: rs2_val, rd: cur_instr.body.R.rd, imm: imm,
                    opnd_1_sel: opnd_1_sel, opnd_2_sel: opnd_2_sel, optr: optr,
                    use_optr: use_optr, alt_out: alt_out, reg_wr_en: reg_wr_en,
                    mem_rd_en: mem_rd_en, mem_wr_en: mem_wr_en,
                    br_inv: cur_instr.body.R.funct3[0], stall_state: stall_state};

de_pipe_reg de_pipe_reg_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_bundle (bundle_d),
    .o_bundle (bundle_q)
);

execute_unit execute_unit_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_bundle      (bundle_q),
    .o_wr_en       (wb_en),
    .o_rd          (wb_rd),
    .o_wr_data     (wb_data),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_retire      (o_retire)
);

endmodule

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_tb;

import rv_pkg::*;

localparam int CLK_PERIOD   = 100;
localparam int RESET_CYCLES = 8;
localparam int IMEM_WORDS   = 1024;
localparam int DMEM_AW      = $clog2(`RV_DMEM_WORDS);

localparam logic [6:0] OP_L     = 7'b0000011;
localparam logic [6:0] OP_I     = 7'b0010011;
localparam logic [6:0] OP_S     = 7'b0100011;
localparam logic [6:0] OP_R     = 7'b0110011;
localparam logic [6:0] OP_B     = 7'b1100011;
localparam logic [6:0] OP_AUIPC = 7'b0010111;
localparam logic [6:0] OP_LUI   = 7'b0110111;
localparam logic [6:0] OP_JAL   = 7'b1101111;
localparam logic [6:0] OP_JALR  = 7'b1100111;

localparam int T_ALU    = 0;
localparam int T_UPPER  = 1;
localparam int T_MEM    = 2;
localparam int T_BRANCH = 3;
localparam int T_JUMP   = 4;
localparam int T_X0     = 5;
localparam int T_FILL   = 6;

logic        i_clk      = 1'b0;
logic        i_rst_n    = 1'b0;
logic        reset_seen = 1'b0;
logic        prog_ready = 1'b0;
logic        done       = 1'b0;
instr_val    imem_addr;
instr_val    imem_data;
retire_t     retire;

logic [31:0] prog      [IMEM_WORDS];
int          prog_test [IMEM_WORDS];
int          n_instr   = 0;
int          cur_test  = T_ALU;
logic [31:0] rng       = 32'd77122;
logic [31:0] halt_pc;
int          errors    = 0;
int          retired   = 0;

// Golden model state
logic [31:0] m_pc;
logic [31:0] m_regs [32];
logic [31:0] m_dmem [`RV_DMEM_WORDS];

logic [31:0] iw;
logic [31:0] rs1_v;
logic [31:0] rs2_v;
logic [31:0] imm_i;
logic [31:0] imm_s;
logic [31:0] imm_b;
logic [31:0] imm_u;
logic [31:0] imm_j;
logic [31:0] mem_addr;
logic        st_en;
logic [31:0] exp_pc;
logic [4:0]  exp_rd;
logic        exp_wr_en;
logic [31:0] exp_data;
logic [31:0] exp_next;
int          exp_test;

always #(CLK_PERIOD / 2) i_clk = ~i_clk;

assign imem_data = prog[imem_addr[11:2]];  // Same-cycle instruction return

rv_core_top rv_core_top_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .o_imem_addr (imem_addr),
    .i_imem_data (imem_data),
    .o_retire    (retire)
);

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic string test_name(input int id);
    case (id)
        T_ALU:    return "alu";
        T_UPPER:  return "lui_auipc";
        T_MEM:    return "store_load";
        T_BRANCH: return "branch";
        T_JUMP:   return "jal_jalr";
        T_X0:     return "x0";
        default:  return "fill";
    endcase
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'd0, $signed(a) < $signed(b)};
        3'b011:  return {31'd0, a < b};
        3'b100:  return a ^ b;
        3'b101:
            if (alt)
                return $signed(a) >>> b[4:0];
            else
                return a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_R};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_S};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_B};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

task automatic next_rand(output logic [31:0] v);
    rng = xorshift32(rng);
    v = rng;
endtask

task automatic emit(input logic [31:0] word);
    prog[n_instr]      = word;
    prog_test[n_instr] = cur_test;
    n_instr++;
endtask

task automatic emit_alu_op(input logic is_r, input logic [2:0] f3, input logic alt);
    logic [31:0] v;
    logic        sub_sra;
    logic [11:0] imm;
    next_rand(v);
    sub_sra = alt && (f3 == 3'b101 || (is_r && f3 == 3'b000));
    if (f3 == 3'b001 || f3 == 3'b101)
        imm = {1'b0, sub_sra, 5'd0, v[29:25]};  // shamt form
    else
        imm = v[31:20];
    if (is_r)
        emit(enc_r({1'b0, sub_sra, 5'd0}, v[4:0], v[9:5], f3, v[14:10]));
    else
        emit(enc_i(imm, v[9:5], f3, v[14:10], OP_I));
endtask

// Offset 8 skips the filler when taken
task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OP_I));
endtask

task automatic build_program();
    logic [31:0] v;
    logic [31:0] w;
    for (int i = 0; i < IMEM_WORDS; i++)
    begin
        prog[i]      = {i[24:0], 7'h7f};  // Unknown opcode, unique per word
        prog_test[i] = T_FILL;
    end
    cur_test = T_ALU;
    for (int r = 1; r < 32; r++)
    begin
        next_rand(v);
        emit(enc_i(v[11:0], r[4:0], 3'b000, r[4:0], OP_LUI) & 32'hffff_f07f
             | {v[31:12], 12'h000} | {20'd0, r[4:0], OP_LUI});
        emit(enc_i(v[11:0], r[4:0], 3'b000, r[4:0], OP_I));
    end
    for (int f = 0; f < 8; f++)
        for (int k = 0; k < 4; k++)
            emit_alu_op(k[0], f[2:0], k[1]);
    for (int k = 0; k < 16; k++)
    begin
        next_rand(v);
        emit_alu_op(v[0], v[3:1], v[4]);
    end
    cur_test = T_UPPER;
    for (int k = 0; k < 4; k++)
    begin
        next_rand(v);
        emit({v[31:12], v[4:0], OP_LUI});
        emit({v[27:8], v[9:5], OP_AUIPC});
    end
    cur_test = T_MEM;
    for (int k = 0; k < 4; k++)
    begin
        next_rand(v);
        next_rand(w);
        emit({v[31:12], 5'd11, OP_LUI});
        emit(enc_i(v[11:0], 5'd11, 3'b000, 5'd11, OP_I));
        emit(enc_i({2'b00, w[7:0], 2'b00}, 5'd0, 3'b000, 5'd10, OP_I));
        emit(enc_s(12'd0, 5'd11, 5'd10));
        emit(enc_i(12'd0, 5'd10, 3'b010, 5'd12, OP_L));
    end
    cur_test = T_BRANCH;
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_I));
    emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, OP_I));  // x2 = -3
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd3, OP_I));
    emit_branch(3'b000, 5'd1, 5'd3);
    emit_branch(3'b000, 5'd1, 5'd2);
    emit_branch(3'b001, 5'd1, 5'd2);
    emit_branch(3'b001, 5'd1, 5'd3);
    emit_branch(3'b100, 5'd2, 5'd1);
    emit_branch(3'b100, 5'd1, 5'd2);
    emit_branch(3'b101, 5'd1, 5'd2);
    emit_branch(3'b101, 5'd2, 5'd1);
    emit_branch(3'b110, 5'd1, 5'd2);
    emit_branch(3'b110, 5'd2, 5'd1);
    emit_branch(3'b111, 5'd2, 5'd1);
    emit_branch(3'b111, 5'd1, 5'd2);
    cur_test = T_JUMP;
    next_rand(v);
    emit(enc_j(21'd8, v[4:0]));
    emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OP_I));
    emit(enc_j(21'd12, 5'd22));
    emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OP_I));
    emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OP_I));
    emit({20'd0, 5'd20, OP_AUIPC});
    emit(enc_i(12'd13, 5'd20, 3'b000, 5'd21, OP_JALR));  // Odd offset, bit 0 dropped
    emit(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OP_I));
    cur_test = T_X0;
    emit(enc_i(12'd77, 5'd5, 3'b000, 5'd0, OP_I));
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd6));
    emit(enc_r(7'h20, 5'd5, 5'd0, 3'b000, 5'd8));
    emit({20'h12345, 5'd0, OP_LUI});
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd9));
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd13, OP_I));
    halt_pc = 32'(n_instr * 4);
    emit(enc_j(21'd0, 5'd0));  // Spin in place
endtask

task automatic report_mismatch(input int tid, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
    errors++;
    $display("MISMATCH %s %s: expected %h actual %h", test_name(tid), field, exp_v, act_v);
endtask

task automatic report_failure(input string msg);
    errors++;
    $display("ERROR: %s", msg);
endtask

always_comb
begin
    iw        = prog[m_pc[11:2]];
    rs1_v     = m_regs[iw[19:15]];
    rs2_v     = m_regs[iw[24:20]];
    imm_i     = {{20{iw[31]}}, iw[31:20]};
    imm_s     = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    imm_b     = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
    imm_u     = {iw[31:12], 12'h000};
    imm_j     = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
    exp_pc    = m_pc;
    exp_test  = prog_test[m_pc[11:2]];
    exp_rd    = iw[11:7];
    exp_wr_en = 1'b0;
    exp_data  = '0;
    exp_next  = m_pc + 32'd4;
    st_en     = 1'b0;
    mem_addr  = rs1_v + imm_i;
    case (iw[6:0])
        OP_I:
        begin
            exp_wr_en = 1'b1;
            exp_data  = alu_ref(iw[14:12], iw[30] && iw[14:12] == 3'b101, rs1_v, imm_i);
        end
        OP_R:
        begin
            exp_wr_en = 1'b1;
            exp_data  = alu_ref(iw[14:12], iw[30], rs1_v, rs2_v);
        end
        OP_LUI:
        begin
            exp_wr_en = 1'b1;
            exp_data  = imm_u;
        end
        OP_AUIPC:
        begin
            exp_wr_en = 1'b1;
            exp_data  = m_pc + imm_u;
        end
        OP_L:
        begin
            exp_wr_en = 1'b1;
            exp_data  = m_dmem[mem_addr[DMEM_AW+1:2]];
        end
        OP_S:
        begin
            st_en    = 1'b1;
            mem_addr = rs1_v + imm_s;
        end
        OP_B:
            if (branch_ref(iw[14:12], rs1_v, rs2_v))
                exp_next = m_pc + imm_b;
        OP_JAL:
        begin
            exp_wr_en = 1'b1;
            exp_data  = m_pc + 32'd4;
            exp_next  = m_pc + imm_j;
        end
        OP_JALR:
        begin
            exp_wr_en = 1'b1;
            exp_data  = m_pc + 32'd4;
            exp_next  = (rs1_v + imm_i) & ~32'd1;
        end
        default:
            exp_wr_en = 1'b0;  // Unknown opcode retires quietly
    endcase
end

// Model steps once per retire
always @(posedge i_clk)
begin
    if (!i_rst_n)
    begin
        reset_seen <= 1'b1;
        m_pc       <= `RV_RESET_PC;
        for (int i = 0; i < 32; i++)
            m_regs[i] <= '0;
    end
    else if (retire.valid)
    begin
        if (exp_wr_en && exp_rd != 5'd0)
            m_regs[exp_rd] <= exp_data;
        if (st_en)
            m_dmem[mem_addr[DMEM_AW+1:2]] <= rs2_v;
        m_pc    <= exp_next;
        retired <= retired + 1;
        if (m_pc == halt_pc)
            done <= 1'b1;
    end
end

a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n && reset_seen |-> !retire.valid)
    else report_failure("retire valid while reset is held");

a_ret_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        retire.valid |-> retire.pc == exp_pc)
    else report_mismatch($sampled(exp_test), "pc", $sampled(exp_pc), $sampled(retire.pc));

a_ret_wr_en: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        retire.valid |-> retire.wr_en == exp_wr_en)
    else report_mismatch($sampled(exp_test), "wr_en", 32'($sampled(exp_wr_en)),
                         32'($sampled(retire.wr_en)));

a_ret_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        retire.valid && exp_wr_en |-> retire.rd == exp_rd)
    else report_mismatch($sampled(exp_test), "rd", 32'($sampled(exp_rd)),
                         32'($sampled(retire.rd)));

a_ret_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        retire.valid && exp_wr_en |-> retire.data == exp_data)
    else report_mismatch($sampled(exp_test), "data", $sampled(exp_data),
                         $sampled(retire.data));

initial
begin
    build_program();
    prog_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    wait (done);
    repeat (2) @(posedge i_clk);
    $display("Retired %0d instructions, %0d errors", retired, errors);
    if (errors == 0)
        $display("*** PASSED ***");
    else
        $display("*** FAILED ***");
    $finish;
end

initial
begin
    wait (prog_ready);
    #((3 * n_instr + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the program reached its last instruction");
    $display("*** FAILED ***");
    $finish;
end

endmodule

// File: src.f
+incdir+hw
hw/rv_pkg.sv
hw/alu.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/de_pipe_reg.sv
hw/execute_unit.sv
hw/rv_core_top.sv
tests/rv_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= rv_core_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
SEED_FLAGS ?= +verilator+seed+77122
VFLAGS     ?= --timing --assert

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SEED_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
